/* build.f */
+incdir+rtl
rtl/spi_pkg.sv
rtl/bus_pkg.sv
rtl/spi_rx_deser.sv
rtl/spi_tx_ser.sv
rtl/spi_bus_master.sv
rtl/reg_bank.sv
rtl/spi_reg_top.sv
verif/spi_clk_gen.sv
verif/spi_props.sv
verif/spi_tb.sv

/* Bender.yml */
package:
  name: spi_reg_slave

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/spi_pkg.sv
      - rtl/bus_pkg.sv
      - rtl/spi_rx_deser.sv
      - rtl/spi_tx_ser.sv
      - rtl/spi_bus_master.sv
      - rtl/reg_bank.sv
      - rtl/spi_reg_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/spi_clk_gen.sv
      - verif/spi_props.sv
      - verif/spi_tb.sv

/* verif/spi_tb.sv */
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_tb;

   localparam int ACTIVE_TIMEOUT = 16;  // clk cycles for active_o to follow csn
   localparam int N_RANDOM       = 200;

   logic clk, rst, sck, csn, mosi;
   logic miso, active, overflow, underrun;
   logic [7:0] model [`SPI_REG_COUNT];  // expected register contents
   logic [7:0] tx_q [$];                 // mosi bytes of the next frame
   logic [7:0] rx_q [$];                 // miso bytes seen in the last frame
   int half;                             // sck half period in clk cycles

   spi_clk_gen u_clk_gen (.clk_o(clk));

   spi_reg_top spi_reg_top_i (
      .clk_i      (clk),
      .rst_i      (rst),
      .sck_i      (sck),
      .csn_i      (csn),
      .mosi_i     (mosi),
      .miso_o     (miso),
      .active_o   (active),
      .overflow_o (overflow),
      .underrun_o (underrun)
   );

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
      if (actual !== expected)
         fail_stop($sformatf("CHECK FAILED %s expected %02h actual %02h",
                             name, expected, actual));
   endtask

   // pins change 1 ns after the rising edge
   task automatic clk_wait(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic wait_active(input logic level, input string what);
      int n;
      n = 0;
      while (active !== level) begin
         if (n == ACTIVE_TIMEOUT)
            fail_stop($sformatf("timeout, active_o never went to %0b after %s", level, what));
         clk_wait(1);
         n++;
      end
   endtask

   function automatic logic [6:0] pick_adr();
      if ($urandom % 4 == 0)
         return 7'($urandom);              // anywhere including past the bank or across the wrap
      return 7'($urandom % `SPI_REG_COUNT);
   endfunction

   // ------------------------------------------------------------
   // spi master, mode 0, msb first
   // ------------------------------------------------------------
   task automatic shift_byte(input logic [7:0] tx_b, input int nbits, output logic [7:0] rx_b);
      rx_b = 8'h00;
      for (int i = 7; i > 7 - nbits; i--) begin
         mosi = tx_b[i];                   // set up while sck low
         clk_wait(half);
         rx_b[i] = miso;                   // sampled at the rising edge
         sck = 1'b1;
         clk_wait(half);
         sck = 1'b0;
      end
   endtask

   // sends tx_q, then cut_bits of one more byte if nonzero
   task automatic run_frame(input string name, input int cut_bits);
      logic [7:0] rx_b;
      rx_q.delete();
      half = 4 + ($urandom % 5);
      csn = 1'b0;
      wait_active(1'b1, "chip select fell");
      foreach (tx_q[k]) begin
         shift_byte(tx_q[k], 8, rx_b);
         rx_q.push_back(rx_b);
      end
      if (cut_bits > 0)
         shift_byte(8'($urandom), cut_bits, rx_b);
      clk_wait(half);
      csn  = 1'b1;
      mosi = 1'b0;
      wait_active(1'b0, "chip select rose");
      check_value({name, " header"}, `SPI_HEADER_BYTE, rx_q[0]);
      check_value({name, " overflow"}, 8'h00, overflow);
      check_value({name, " underrun"}, 8'h00, underrun);
      clk_wait(4);                         // gap between frames
   endtask

   task automatic write_burst(input logic [6:0] start, input int len, input int cut_bits,
                              input string name);
      logic [6:0] a;
      tx_q.delete();
      tx_q.push_back({1'b1, start});
      for (int k = 0; k < len; k++)
         tx_q.push_back(8'($urandom));
      run_frame(name, cut_bits);
      a = start;
      for (int k = 1; k <= len; k++) begin
         if (a < `SPI_REG_COUNT)
            model[a] = tx_q[k];            // out of range writes vanish
         a = a + 7'd1;
      end
   endtask

   task automatic read_burst(input logic [6:0] start, input int len, input string name);
      logic [6:0] a;
      logic [7:0] exp_b;
      tx_q.delete();
      tx_q.push_back({1'b0, start});
      for (int k = 0; k < len; k++)
         tx_q.push_back(8'($urandom));     // ignored by the slave
      run_frame(name, 0);
      a = start;
      for (int k = 1; k <= len; k++) begin
         exp_b = (a < `SPI_REG_COUNT) ? model[a] : 8'h00;
         check_value($sformatf("%s adr %02h", name, a), exp_b, rx_q[k]);
         a = a + 7'd1;
      end
   endtask

   // ------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------
   initial begin
      logic [6:0] start;
      int len;
      rst  = 1'b1;
      sck  = 1'b0;
      csn  = 1'b1;
      mosi = 1'b0;
      void'($urandom(32'he593_79a4));
      foreach (model[i])
         model[i] = 8'h00;
      clk_wait(3);
      rst = 1'b0;
      clk_wait(2);

      check_value("reset active_o", 8'h00, active);
      check_value("reset overflow_o", 8'h00, overflow);
      check_value("reset underrun_o", 8'h00, underrun);
      check_value("reset miso_o", 8'h01, miso);

      // burst write then read back from the same start
      start = 7'($urandom % `SPI_REG_COUNT);
      len   = 1 + ($urandom % 8);
      write_burst(start, len, 0, "burst write");
      read_burst(start, len, "burst read");
      // across the end of the bank where the upper part reads zero
      write_burst(7'(`SPI_REG_COUNT - 3), 7, 0, "edge write");
      read_burst(7'(`SPI_REG_COUNT - 4), 8, "edge read");

      // short last byte is dropped while full bytes before it land
      start = 7'($urandom % `SPI_REG_COUNT);
      write_burst(start, $urandom % 3, 1 + ($urandom % 7), "cut write");
      read_burst(start, 4, "after cut read");

      for (int n = 0; n < N_RANDOM; n++) begin
         start = pick_adr();
         len   = 1 + ($urandom % 8);
         if ($urandom % 2)
            write_burst(start, len, 0, $sformatf("random %0d write", n));
         else
            read_burst(start, len, $sformatf("random %0d read", n));
      end

      $display("All tests passed!");
      $finish;
   end

endmodule

/* verif/spi_props.sv */
`timescale 1ns/1ps

module spi_props (
   input logic               clk_i,
   input logic               rst_i,
   input logic               cyc_i,
   input logic               stb_i,
   input logic               ack_i,
   input logic               tx_valid_i,
   input logic               tx_ready_i,
   input bus_pkg::bm_state_e state_i
);

   // ------------------------------------------------------------
   // register bus cycles
   // ------------------------------------------------------------
   ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_i |-> cyc_i && stb_i)
      else $error("ack seen outside an open bus cycle");

   stb_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && !ack_i |=> stb_i)
      else $error("stb dropped before ack");

   stb_after_ack: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !stb_i)
      else $error("stb still high in the cycle after ack");

   bus_idle_in_reset: assert property (@(posedge clk_i) rst_i |=> !cyc_i && !stb_i)
      else $error("cyc or stb high during reset");

   cyc_state: assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_i |-> state_i inside {bus_pkg::WRITE, bus_pkg::READ})
      else $error("bus cycle open outside WRITE or READ");

   // ------------------------------------------------------------
   // transmit handshake
   // ------------------------------------------------------------
   tx_valid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      tx_valid_i && !tx_ready_i |=> tx_valid_i)
      else $error("tx_valid withdrawn before tx_ready");

endmodule

bind spi_bus_master spi_props u_props (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .cyc_i      (cyc_o),
   .stb_i      (stb_o),
   .ack_i      (ack_i),
   .tx_valid_i (tx_valid_o),
   .tx_ready_i (tx_ready_i),
   .state_i    (state_q)
);

/* verif/spi_clk_gen.sv */
`timescale 1ns/1ps

module spi_clk_gen (
   output logic clk_o
);

   // 4 ns period, first rising edge at 2 ns
   initial clk_o = 1'b0;

   always #2 clk_o = ~clk_o;

endmodule

/* rtl/spi_reg_top.sv */
`timescale 1ns/1ps

module spi_reg_top (
   input  logic clk_i,
   input  logic rst_i,
   input  logic sck_i,
   input  logic csn_i,
   input  logic mosi_i,
   output logic miso_o,
   output logic active_o,
   output logic overflow_o,
   output logic underrun_o
);

   // ------------------------------------------------------------
   // spi halves <-> bus master <-> register bank
   // ------------------------------------------------------------
   logic       rx_valid, rx_ready, rx_first;
   logic [7:0] rx_data;
   logic       frame_active, sck_fall;
   logic       tx_valid, tx_ready;
   logic [7:0] tx_data;
   logic       cyc, stb, we, ack;
   bus_pkg::bus_adr_t adr;
   bus_pkg::bus_dat_t dat_w, dat_r;

   assign active_o = frame_active;

   spi_rx_deser u_rx_deser (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .sck_i          (sck_i),
      .csn_i          (csn_i),
      .mosi_i         (mosi_i),
      .rx_ready_i     (rx_ready),
      .rx_valid_o     (rx_valid),
      .rx_data_o      (rx_data),
      .rx_first_o     (rx_first),
      .frame_active_o (frame_active),
      .sck_fall_o     (sck_fall),
      .overflow_o     (overflow_o)
   );

   spi_tx_ser u_tx_ser (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .frame_active_i (frame_active),
      .sck_fall_i     (sck_fall),
      .tx_valid_i     (tx_valid),
      .tx_data_i      (tx_data),
      .tx_ready_o     (tx_ready),
      .miso_o         (miso_o),
      .underrun_o     (underrun_o)
   );

   spi_bus_master u_bus_master (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .rx_valid_i     (rx_valid),
      .rx_data_i      (rx_data),
      .rx_first_i     (rx_first),
      .rx_ready_o     (rx_ready),
      .frame_active_i (frame_active),
      .tx_ready_i     (tx_ready),
      .tx_valid_o     (tx_valid),
      .tx_data_o      (tx_data),
      .cyc_o          (cyc),
      .stb_o          (stb),
      .we_o           (we),
      .adr_o          (adr),
      .dat_o          (dat_w),
      .ack_i          (ack),
      .dat_i          (dat_r)
   );

   reg_bank u_reg_bank (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .cyc_i (cyc),
      .stb_i (stb),
      .we_i  (we),
      .adr_i (adr),
      .dat_i (dat_w),
      .ack_o (ack),
      .dat_o (dat_r)
   );

endmodule

/* rtl/reg_bank.sv */
`timescale 1ns/1ps
`include "spi_settings.svh"

module reg_bank (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              cyc_i,
   input  logic              stb_i,
   input  logic              we_i,
   input  bus_pkg::bus_adr_t adr_i,
   input  bus_pkg::bus_dat_t dat_i,
   output logic              ack_o,
   output bus_pkg::bus_dat_t dat_o
);

   localparam int IDX_W = $clog2(`SPI_REG_COUNT);

   bus_pkg::bus_dat_t regs [`SPI_REG_COUNT];
   logic in_range;
   logic req;                       // new request, one per cycle

   assign in_range = (adr_i < `SPI_REG_COUNT);
   assign req      = cyc_i && stb_i && !ack_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
         for (int i = 0; i < `SPI_REG_COUNT; i++)
            regs[i] <= '0;
      end else begin
         ack_o <= req;              // one cycle pulse after stb
         if (req && we_i && in_range)
            regs[adr_i[IDX_W-1:0]] <= dat_i;
      end
   end

   // read data lands together with ack
   always_ff @(posedge clk_i) begin
      if (req)
         dat_o <= in_range ? regs[adr_i[IDX_W-1:0]] : '0;
   end

endmodule

/* rtl/spi_bus_master.sv */
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_bus_master (
   input  logic              clk_i,
   input  logic              rst_i,
   // receive side
   input  logic              rx_valid_i,
   input  logic [7:0]        rx_data_i,
   input  logic              rx_first_i,
   output logic              rx_ready_o,
   input  logic              frame_active_i,
   // transmit side
   input  logic              tx_ready_i,
   output logic              tx_valid_o,
   output logic [7:0]        tx_data_o,
   // register bus
   output logic              cyc_o,
   output logic              stb_o,
   output logic              we_o,
   output bus_pkg::bus_adr_t adr_o,
   output bus_pkg::bus_dat_t dat_o,
   input  logic              ack_i,
   input  bus_pkg::bus_dat_t dat_i
);

   bus_pkg::bm_state_e state_q;
   spi_pkg::spi_byte_u rx_byte;     // command or data view of rx_data_i
   bus_pkg::bus_adr_t  adr_q;       // burst address counter
   logic wr_q;                      // write frame
   logic cyc_q;
   logic rx_hs, tx_hs;

   assign rx_byte = rx_data_i;
   assign rx_hs   = rx_valid_i && rx_ready_o;
   assign tx_hs   = tx_valid_o && tx_ready_i;

   // no bytes taken while a bus cycle is open
   assign rx_ready_o = (state_q == bus_pkg::IDLE) ||
                       (state_q == bus_pkg::CMD)  ||
                       (state_q == bus_pkg::WAIT);

   // single beat cycles, stb tracks cyc
   assign cyc_o = cyc_q;
   assign stb_o = cyc_q;
   assign we_o  = wr_q;
   assign adr_o = adr_q;

   // ------------------------------------------------------------
   // FSM, bus cycles and tx queue
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q    <= bus_pkg::IDLE;
         cyc_q      <= 1'b0;
         tx_valid_o <= 1'b0;
         wr_q       <= 1'b0;
         adr_q      <= '0;
      end else begin
         if (tx_hs)
            tx_valid_o <= 1'b0;
         unique case (state_q)
            bus_pkg::IDLE: begin
               // header waits here, tx side only takes it once csn is low
               tx_valid_o <= !tx_hs;
               tx_data_o  <= `SPI_HEADER_BYTE;
               if (tx_hs)
                  state_q <= bus_pkg::CMD;
            end
            bus_pkg::CMD: begin
               if (!frame_active_i)
                  state_q <= bus_pkg::IDLE;
               else if (rx_hs && rx_first_i) begin
                  wr_q  <= rx_byte.cmd.wr;
                  adr_q <= rx_byte.cmd.adr;
                  if (rx_byte.cmd.wr) begin
                     tx_valid_o <= 1'b1;          // echo keeps miso fed
                     tx_data_o  <= rx_byte.raw;
                     state_q    <= bus_pkg::WAIT;
                  end else begin
                     cyc_q   <= 1'b1;             // first read right away
                     state_q <= bus_pkg::READ;
                  end
               end
            end
            bus_pkg::WAIT: begin
               if (!frame_active_i)
                  state_q <= bus_pkg::IDLE;
               else if (wr_q) begin
                  if (rx_hs) begin
                     cyc_q      <= 1'b1;
                     dat_o      <= rx_byte.raw;
                     tx_valid_o <= 1'b1;
                     tx_data_o  <= rx_byte.raw;
                     state_q    <= bus_pkg::WRITE;
                  end
               end else if (tx_hs) begin
                  cyc_q   <= 1'b1;                // prefetch next byte
                  state_q <= bus_pkg::READ;
               end
               // mosi bytes of a read frame are taken and dropped
            end
            bus_pkg::WRITE: begin
               if (ack_i) begin
                  cyc_q   <= 1'b0;
                  adr_q   <= adr_q + 7'd1;
                  state_q <= frame_active_i ? bus_pkg::WAIT : bus_pkg::IDLE;
               end
            end
            bus_pkg::READ: begin
               if (ack_i) begin
                  cyc_q      <= 1'b0;
                  adr_q      <= adr_q + 7'd1;
                  tx_valid_o <= 1'b1;
                  tx_data_o  <= dat_i;
                  state_q    <= frame_active_i ? bus_pkg::WAIT : bus_pkg::IDLE;
               end
            end
            default: state_q <= bus_pkg::IDLE;
         endcase
      end
   end

endmodule

/* rtl/spi_tx_ser.sv */
`timescale 1ns/1ps

module spi_tx_ser (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       frame_active_i,
   input  logic       sck_fall_i,     // synchronized falling sck
   input  logic       tx_valid_i,
   input  logic [7:0] tx_data_i,
   output logic       tx_ready_o,
   output logic       miso_o,
   output logic       underrun_o
);

   logic [7:0] hold_q, shift_q;
   logic hold_vld;                  // holding register full
   logic primed;                    // first byte of the frame loaded
   logic act_q;
   logic [2:0] fall_cnt;
   logic accept, boundary;

   assign tx_ready_o = frame_active_i && !hold_vld;
   assign accept     = tx_valid_i && tx_ready_o;
   assign boundary   = frame_active_i && sck_fall_i && (fall_cnt == 3'd7);
   assign miso_o     = frame_active_i ? shift_q[7] : 1'b1;   // idle high

   // ------------------------------------------------------------
   // control
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         hold_vld   <= 1'b0;
         primed     <= 1'b0;
         fall_cnt   <= 3'd0;
         act_q      <= 1'b0;
         underrun_o <= 1'b0;
      end else begin
         act_q <= frame_active_i;
         if (frame_active_i && !act_q)
            underrun_o <= 1'b0;     // new frame clears the flag
         if (!frame_active_i) begin
            hold_vld <= 1'b0;
            primed   <= 1'b0;
            fall_cnt <= 3'd0;
         end else begin
            if (sck_fall_i)
               fall_cnt <= fall_cnt + 3'd1;
            if (!primed) begin
               // frame start loads the shifter straight from the input
               if (accept)
                  primed <= 1'b1;
               else if (sck_fall_i) begin
                  primed     <= 1'b1;
                  underrun_o <= 1'b1;
               end
            end else if (boundary) begin
               if (hold_vld)
                  hold_vld <= 1'b0;       // holding -> shifter
               else if (!tx_valid_i)
                  underrun_o <= 1'b1;     // nothing to send, FF goes out
            end else if (accept)
               hold_vld <= 1'b1;
         end
      end
   end

   // shifter, late data at a boundary bypasses the holding register
   always_ff @(posedge clk_i) begin
      if (!frame_active_i)
         shift_q <= 8'hFF;
      else if ((!primed || boundary) && accept)
         shift_q <= tx_data_i;
      else if (boundary && hold_vld)
         shift_q <= hold_q;
      else if (sck_fall_i)
         shift_q <= {shift_q[6:0], 1'b1};   // ones fill, so an empty load is FF
      if (accept)
         hold_q <= tx_data_i;
   end

endmodule

/* rtl/spi_rx_deser.sv */
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_rx_deser (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       sck_i,          // raw pin, not a clock
   input  logic       csn_i,          // active low chip select
   input  logic       mosi_i,
   input  logic       rx_ready_i,
   output logic       rx_valid_o,
   output logic [7:0] rx_data_o,
   output logic       rx_first_o,     // byte is the first of its frame
   output logic       frame_active_o,
   output logic       sck_fall_o,
   output logic       overflow_o
);

   // ------------------------------------------------------------
   // pin synchronizers and edge detect
   // ------------------------------------------------------------
   logic [`SPI_SYNC_DEPTH-1:0] sck_sync, csn_sync, mosi_sync;
   logic sck_s, csn_s, mosi_s;
   logic sck_q, csn_q;              // previous synchronized levels
   logic sck_rise, frame_start, byte_done;
   logic [2:0] bit_cnt;
   logic [6:0] shift_q;             // bits 7..1 of the byte in progress
   logic first_pend;                // next byte is the command byte

   assign sck_s  = sck_sync[`SPI_SYNC_DEPTH-1];
   assign csn_s  = csn_sync[`SPI_SYNC_DEPTH-1];
   assign mosi_s = mosi_sync[`SPI_SYNC_DEPTH-1];

   assign sck_rise    = sck_s && !sck_q && !csn_s;
   assign sck_fall_o  = !sck_s && sck_q && !csn_s;   // tx side shifts here
   assign frame_start = !csn_s && csn_q;
   assign byte_done   = sck_rise && (bit_cnt == 3'd7);
   assign frame_active_o = !csn_s;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sck_sync  <= '0;
         csn_sync  <= '1;           // deselected
         mosi_sync <= '0;
      end else begin
         sck_sync  <= {sck_sync[`SPI_SYNC_DEPTH-2:0], sck_i};
         csn_sync  <= {csn_sync[`SPI_SYNC_DEPTH-2:0], csn_i};
         mosi_sync <= {mosi_sync[`SPI_SYNC_DEPTH-2:0], mosi_i};
      end
   end

   // ------------------------------------------------------------
   // bit counter, handshake and flags
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sck_q      <= 1'b0;
         csn_q      <= 1'b1;
         bit_cnt    <= 3'd0;
         rx_valid_o <= 1'b0;
         first_pend <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         sck_q <= sck_s;
         csn_q <= csn_s;
         if (rx_valid_o && rx_ready_i)
            rx_valid_o <= 1'b0;
         if (csn_s)
            bit_cnt <= 3'd0;        // a cut-off byte is thrown away
         else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (byte_done) begin
               rx_valid_o <= 1'b1;
               first_pend <= 1'b0;
               if (rx_valid_o && !rx_ready_i)
                  overflow_o <= 1'b1;   // previous byte never taken
            end
         end
         if (frame_start) begin
            first_pend <= 1'b1;
            overflow_o <= 1'b0;     // sticky per frame
         end
      end
   end

   // msb first, sampled on rising sck
   always_ff @(posedge clk_i) begin
      if (csn_s)
         shift_q <= '0;
      else if (sck_rise)
         shift_q <= {shift_q[5:0], mosi_s};
      if (byte_done) begin
         rx_data_o  <= {shift_q, mosi_s};
         rx_first_o <= first_pend;
      end
   end

endmodule

/* rtl/bus_pkg.sv */
// ------------------------------------------------------------
// register bus types
// ------------------------------------------------------------
package bus_pkg;

   typedef logic [6:0] bus_adr_t;  // 7 bit word address
   typedef logic [7:0] bus_dat_t;  // byte wide data

   // bus master FSM
   typedef enum logic [2:0] {
      IDLE,   // header queued, waiting for frame start
      CMD,    // waiting for the command byte
      WAIT,   // between bytes of a burst
      WRITE,  // bus write in flight
      READ    // bus read in flight
   } bm_state_e;

endpackage

/* rtl/spi_pkg.sv */
// ------------------------------------------------------------
// spi side types
// ------------------------------------------------------------
package spi_pkg;

   // first mosi byte of a frame
   typedef struct packed {
      logic       wr;   // 1 = write frame, 0 = read frame
      logic [6:0] adr;  // start address of the burst
   } spi_cmd_t;

   // a received byte, seen as a command on the first byte of a
   // frame and as plain data on every later one
   typedef union packed {
      spi_cmd_t   cmd;
      logic [7:0] raw;
   } spi_byte_u;

endpackage

/* rtl/spi_settings.svh */
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// ------------------------------------------------------------
// spi slave build constants
// ------------------------------------------------------------

// byte returned on miso while the command byte comes in
`define SPI_HEADER_BYTE 8'hA7

// register bank size, higher addresses read as zero
`define SPI_REG_COUNT 16

// flops per pin in the sck/csn/mosi synchronizers
`define SPI_SYNC_DEPTH 2

`endif
